/* Makefile */
TOP := pmem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module pmem_top

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) --Mdir obj_dir -o pmem_sim
	./obj_dir/pmem_sim | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/pmem_tb.sv */
`timescale 1ns/1ps

module pmem_tb;

    logic clock;
    logic reset;
    int   cycle = 0;                      // rising edges seen so far

    logic awvalid_i, awready_o, wvalid_i, wready_o, wlast_i, arvalid_i, arready_o;
    axi_pkg::addr_t  awaddr_i, araddr_i;
    axi_pkg::id_t    awid_i, arid_i, bid_o, rid_o;
    axi_pkg::len_t   awlen_i, arlen_i;
    axi_pkg::size_t  awsize_i, arsize_i;
    axi_pkg::burst_t awburst_i, arburst_i;
    axi_pkg::data_t  wdata_i, rdata_o;
    axi_pkg::strb_t  wstrb_i;
    axi_pkg::resp_e  bresp_o, rresp_o;
    logic bready_i, bvalid_o, rready_i, rvalid_o, rlast_o;

    logic [15:0] lfsr_q = 16'd41079;

    // stimulus table, one entry per request
    string               t_name  [$];
    pmem_pkg::mem_op_e   t_op    [$];
    axi_pkg::addr_t      t_addr  [$];
    axi_pkg::id_t        t_id    [$];
    axi_pkg::len_t       t_len   [$];
    axi_pkg::size_t      t_size  [$];
    axi_pkg::data_t      t_wdata [$];
    axi_pkg::strb_t      t_strb  [$];
    axi_pkg::resp_e      t_resp  [$];
    axi_pkg::data_t      t_rdata [$];

    pmem_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error %s: expected 0x%0h, actual 0x%0h",
                                     name, expected, actual));
        end
    endtask

    // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic take_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return b;
    endfunction

    task automatic add_entry(input string name, input pmem_pkg::mem_op_e op,
                             input axi_pkg::addr_t addr, input axi_pkg::id_t id,
                             input axi_pkg::len_t len, input axi_pkg::size_t size,
                             input axi_pkg::data_t wdata, input axi_pkg::strb_t strb,
                             input axi_pkg::resp_e resp, input axi_pkg::data_t rdata);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_id.push_back(id);
        t_len.push_back(len);
        t_size.push_back(size);
        t_wdata.push_back(wdata);
        t_strb.push_back(strb);
        t_resp.push_back(resp);
        t_rdata.push_back(rdata);
    endtask

    task automatic load_table();
        pmem_pkg::mem_op_e  w;
        pmem_pkg::mem_op_e  r;
        axi_pkg::resp_e     ok;
        axi_pkg::resp_e     se;
        w  = pmem_pkg::op_write;
        r  = pmem_pkg::op_read;
        ok = axi_pkg::okay;
        se = axi_pkg::slverr;
        add_entry("w_zero", w, 32'h0000, 4'd1, 8'd0, 3'd3, 64'hdead_beef_cafe_f00d, 8'hff, ok, 0);
        add_entry("w_full", w, 32'h0100, 4'd3, 8'd0, 3'd3, 64'h0123_4567_89ab_cdef, 8'hff, ok, 0);
        add_entry("r_full", r, 32'h0100, 4'd5, 8'd0, 3'd3, 0, 0, ok, 64'h0123_4567_89ab_cdef);
        add_entry("w_part", w, 32'h0100, 4'd6, 8'd0, 3'd3, 64'hffff_ffff_1122_3344, 8'h0f, ok, 0);
        add_entry("r_part", r, 32'h0100, 4'd7, 8'd0, 3'd3, 0, 0, ok, 64'h0123_4567_1122_3344);
        add_entry("w_top",  w, 32'h1ff8, 4'd8, 8'd0, 3'd3, 64'h1357_9bdf_0246_8ace, 8'hff, ok, 0);
        add_entry("r_top",  r, 32'h1ff8, 4'd9, 8'd0, 3'd3, 0, 0, ok, 64'h1357_9bdf_0246_8ace);
        add_entry("w_range", w, 32'h2000, 4'd10, 8'd0, 3'd3, 64'h1111_2222_3333_4444, 8'hff,
                  se, 0);
        add_entry("r_range", r, 32'h2000, 4'd11, 8'd0, 3'd3, 0, 0, se, 0);
        add_entry("w_len",  w, 32'h0100, 4'd12, 8'd1, 3'd3, 64'h5555_6666_7777_8888, 8'hff, se, 0);
        add_entry("r_len",  r, 32'h0100, 4'd13, 8'd3, 3'd3, 0, 0, se, 0);
        add_entry("w_size", w, 32'h0100, 4'd14, 8'd0, 3'd4, 64'h9999_aaaa_bbbb_cccc, 8'hff, se, 0);
        add_entry("r_size", r, 32'h0100, 4'd15, 8'd0, 3'd5, 0, 0, se, 0);
        add_entry("r_keep", r, 32'h0100, 4'd2, 8'd0, 3'd3, 0, 0, ok, 64'h0123_4567_1122_3344);
        add_entry("r_zero", r, 32'h0000, 4'd4, 8'd0, 3'd3, 0, 0, ok, 64'hdead_beef_cafe_f00d);
    endtask

    function automatic logic signal_high(input int which);
        case (which)
            0:       return awready_o && wready_o;
            1:       return arready_o;
            2:       return bvalid_o;
            3:       return rvalid_o;
            default: return bvalid_o || rvalid_o;
        endcase
    endfunction

    // sampled on the falling edge, where every output has settled
    task automatic wait_high(input int which, input string what);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < 50 && !seen; n++) begin
            @(negedge clock);
            seen = signal_high(which);
        end
        if (!seen) begin
            report_failure($sformatf("timed out after 50 cycles waiting for %s", what));
        end
    endtask

    task automatic drive_request(input int i);
        if (t_op[i] == pmem_pkg::op_write) begin
            awvalid_i = 1'b1;
            awaddr_i  = t_addr[i];
            awid_i    = t_id[i];
            awlen_i   = t_len[i];
            awsize_i  = t_size[i];
            wvalid_i  = 1'b1;
            wdata_i   = t_wdata[i];
            wstrb_i   = t_strb[i];
        end else begin
            arvalid_i = 1'b1;
            araddr_i  = t_addr[i];
            arid_i    = t_id[i];
            arlen_i   = t_len[i];
            arsize_i  = t_size[i];
        end
    endtask

    task automatic check_response(input int i);
        if (t_op[i] == pmem_pkg::op_write) begin
            check_value({t_name[i], " bvalid"}, 64'd1, 64'(bvalid_o));
            check_value({t_name[i], " rvalid"}, 64'd0, 64'(rvalid_o));
            check_value({t_name[i], " bresp"}, 64'(t_resp[i]), 64'(bresp_o));
            check_value({t_name[i], " bid"}, 64'(t_id[i]), 64'(bid_o));
        end else begin
            check_value({t_name[i], " rvalid"}, 64'd1, 64'(rvalid_o));
            check_value({t_name[i], " bvalid"}, 64'd0, 64'(bvalid_o));
            check_value({t_name[i], " rresp"}, 64'(t_resp[i]), 64'(rresp_o));
            check_value({t_name[i], " rid"}, 64'(t_id[i]), 64'(rid_o));
            check_value({t_name[i], " rdata"}, t_rdata[i], rdata_o);
            check_value({t_name[i], " rlast"}, 64'd1, 64'(rlast_o));
        end
    endtask

    task automatic run_entry(input int i);
        logic [1:0] bits;
        int         stall;
        int         hs_cycle;
        logic       is_write;
        bits[1]  = take_bit();
        bits[0]  = take_bit();
        stall    = int'(bits);
        is_write = (t_op[i] == pmem_pkg::op_write);
        if (stall == 0) begin
            bready_i = 1'b1;               // no stall, the response is taken at once
            rready_i = 1'b1;
        end
        drive_request(i);
        wait_high(is_write ? 0 : 1, {t_name[i], " request ready"});
        hs_cycle  = cycle;                 // edges up to the one before the handshake edge
        @(posedge clock);
        #1;
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        arvalid_i = 1'b0;
        wait_high(is_write ? 2 : 3, {t_name[i], " response valid"});
        check_value({t_name[i], " latency"}, 64'd3, 64'(cycle - hs_cycle));
        check_response(i);
        for (int k = 0; k < stall; k++) begin
            @(posedge clock);
            #1;
            if (k == stall - 1) begin
                bready_i = 1'b1;
                rready_i = 1'b1;
            end
            @(negedge clock);
            check_response(i);             // held payload must not move while stalled
        end
        @(posedge clock);
        #1;
        bready_i = 1'b0;
        rready_i = 1'b0;
    endtask

    // a write and a read offered together, the write goes first
    task automatic run_priority();
        bready_i  = 1'b1;
        rready_i  = 1'b1;
        awvalid_i = 1'b1;
        awaddr_i  = 32'h0200;
        awid_i    = 4'd9;
        awlen_i   = 8'd0;
        awsize_i  = 3'd3;
        wvalid_i  = 1'b1;
        wdata_i   = 64'h5a5a_a5a5_0f0f_f0f0;
        wstrb_i   = 8'hff;
        arvalid_i = 1'b1;
        araddr_i  = 32'h0200;
        arid_i    = 4'd10;
        arlen_i   = 8'd0;
        arsize_i  = 3'd3;
        wait_high(0, "priority write ready");
        check_value("prio arready", 64'd0, 64'(arready_o));
        @(posedge clock);
        #1;
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        wait_high(1, "priority read ready");
        @(posedge clock);
        #1;
        arvalid_i = 1'b0;
        wait_high(4, "priority first response");
        check_value("prio bvalid first", 64'd1, 64'(bvalid_o));
        check_value("prio rvalid before b", 64'd0, 64'(rvalid_o));
        check_value("prio bresp", 64'(axi_pkg::okay), 64'(bresp_o));
        check_value("prio bid", 64'd9, 64'(bid_o));
        @(posedge clock);
        #1;
        wait_high(3, "priority read response");
        check_value("prio rresp", 64'(axi_pkg::okay), 64'(rresp_o));
        check_value("prio rid", 64'd10, 64'(rid_o));
        check_value("prio rdata", 64'h5a5a_a5a5_0f0f_f0f0, rdata_o);
        @(posedge clock);
        #1;
        bready_i = 1'b0;
        rready_i = 1'b0;
    endtask

    initial begin
        reset     = 1'b1;
        awvalid_i = 1'b0;
        awaddr_i  = '0;
        awid_i    = '0;
        awlen_i   = '0;
        awsize_i  = '0;
        awburst_i = 2'b01;
        wvalid_i  = 1'b0;
        wdata_i   = '0;
        wstrb_i   = '0;
        wlast_i   = 1'b1;
        arvalid_i = 1'b0;
        araddr_i  = '0;
        arid_i    = '0;
        arlen_i   = '0;
        arsize_i  = '0;
        arburst_i = 2'b01;
        bready_i  = 1'b0;
        rready_i  = 1'b0;
        load_table();
        repeat (2) @(posedge clock);
        @(negedge clock);
        check_value("reset awready", 64'd0, 64'(awready_o));
        check_value("reset arready", 64'd0, 64'(arready_o));
        check_value("reset bvalid", 64'd0, 64'(bvalid_o));
        @(posedge clock);
        #1;
        reset = 1'b0;
        @(posedge clock);                  // first edge that sees reset low
        @(negedge clock);
        check_value("after reset awready", 64'd1, 64'(awready_o));
        check_value("after reset wready", 64'd1, 64'(wready_o));
        check_value("after reset arready", 64'd1, 64'(arready_o));
        check_value("after reset bvalid", 64'd0, 64'(bvalid_o));
        check_value("after reset rvalid", 64'd0, 64'(rvalid_o));
        @(posedge clock);
        #1;
        for (int i = 0; i < t_name.size(); i++) begin
            run_entry(i);
        end
        run_priority();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* sim.f */
+incdir+source
source/axi_pkg.sv
source/pmem_pkg.sv
source/mem_req_if.sv
source/mem_rsp_if.sv
source/pmem_accept.sv
source/pmem_array.sv
source/pmem_respond.sv
source/pmem_top.sv
dv/pmem_tb.sv

/* source/axi_pkg.sv */
`include "pmem_params.svh"

package axi_pkg;

    typedef logic [`PMEM_ADDR_W-1:0] addr_t;      // byte address

    typedef logic [`PMEM_DATA_W-1:0] data_t;      // one data beat

    typedef logic [`PMEM_DATA_W/8-1:0] strb_t;    // one strobe bit per byte lane

    typedef logic [`PMEM_ID_W-1:0] id_t;          // transaction ID

    typedef logic [7:0] len_t;                    // beats in the burst minus one

    typedef logic [2:0] size_t;                   // log2 of the bytes in a beat

    typedef logic [1:0] burst_t;                  // fixed, incr or wrap

    // response codes as they appear on bresp and rresp
    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } resp_e;

endpackage

/* source/mem_req_if.sv */
`timescale 1ns/1ps

// checked requests handed from the accept stage to the array stage
interface mem_req_if;

    logic                  valid;
    logic                  ready;
    pmem_pkg::mem_op_e     op;
    pmem_pkg::word_idx_t   idx;
    axi_pkg::data_t        wdata;
    axi_pkg::strb_t        wstrb;
    axi_pkg::id_t          id;
    logic                  err;      // request failed length, size or range checks

    modport accept_mp (
        output valid, op, idx, wdata, wstrb, id, err,
        input  ready
    );

    modport array_mp (
        input  valid, op, idx, wdata, wstrb, id, err,
        output ready
    );

endinterface

/* source/mem_rsp_if.sv */
`timescale 1ns/1ps

// completed accesses handed from the array stage to the respond stage
interface mem_rsp_if;

    logic                valid;
    logic                ready;
    pmem_pkg::mem_op_e   op;         // selects the B or the R channel
    axi_pkg::data_t      rdata;
    axi_pkg::id_t        id;
    axi_pkg::resp_e      resp;

    modport array_mp (
        output valid, op, rdata, id, resp,
        input  ready
    );

    modport respond_mp (
        input  valid, op, rdata, id, resp,
        output ready
    );

endinterface

/* source/pmem_accept.sv */
`timescale 1ns/1ps
`include "pmem_params.svh"

module pmem_accept (
    input  logic                 clock,
    input  logic                 reset,

    input  logic                 awvalid_i,
    input  axi_pkg::addr_t       awaddr_i,
    input  axi_pkg::id_t         awid_i,
    input  axi_pkg::len_t        awlen_i,
    input  axi_pkg::size_t       awsize_i,
    output logic                 awready_o,

    input  logic                 wvalid_i,
    input  axi_pkg::data_t       wdata_i,
    input  axi_pkg::strb_t       wstrb_i,
    output logic                 wready_o,

    input  logic                 arvalid_i,
    input  axi_pkg::addr_t       araddr_i,
    input  axi_pkg::id_t         arid_i,
    input  axi_pkg::len_t        arlen_i,
    input  axi_pkg::size_t       arsize_i,
    output logic                 arready_o,

    mem_req_if.accept_mp         req
);

    pmem_pkg::accept_state_e state_q;
    logic                    accept_en_q;   // low through reset, high from the next clock on

    pmem_pkg::mem_op_e       op_q;
    pmem_pkg::word_idx_t     idx_q;
    axi_pkg::data_t          wdata_q;
    axi_pkg::strb_t          wstrb_q;
    axi_pkg::id_t            id_q;
    logic                    err_q;

    logic                    slot_free;
    logic                    write_offer;
    logic                    write_go;
    logic                    read_go;

    // only single beats of up to 8 bytes inside the array are served
    function automatic logic bad_request(
        input axi_pkg::addr_t addr,
        input axi_pkg::len_t  len,
        input axi_pkg::size_t size
    );
        return (len != '0) || (size > 3'd3) ||
               (addr[`PMEM_ADDR_W-1:`PMEM_WORDS_LOG2+3] != '0);
    endfunction

    // the register can take a new request if it is empty or drains at this edge
    assign slot_free   = accept_en_q && ((state_q == pmem_pkg::accept_idle) || req.ready);
    assign write_offer = awvalid_i && wvalid_i;                 // AW and W go together
    assign write_go    = slot_free && write_offer;
    assign read_go     = slot_free && arvalid_i && !write_offer; // a write always wins

    assign awready_o = slot_free;
    assign wready_o  = slot_free;
    assign arready_o = slot_free && !write_offer;

    always_ff @(posedge clock) begin
        if (reset) begin
            accept_en_q <= 1'b0;
            state_q     <= pmem_pkg::accept_idle;
        end else begin
            accept_en_q <= 1'b1;
            if (write_go || read_go) begin
                state_q <= pmem_pkg::accept_hold;
            end else if (req.ready) begin
                state_q <= pmem_pkg::accept_idle;  // held request moved on to the array
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_go) begin
            op_q    <= pmem_pkg::op_write;
            idx_q   <= awaddr_i[`PMEM_WORDS_LOG2+2:3];
            wdata_q <= wdata_i;
            wstrb_q <= wstrb_i;
            id_q    <= awid_i;
            err_q   <= bad_request(awaddr_i, awlen_i, awsize_i);
        end else if (read_go) begin
            op_q    <= pmem_pkg::op_read;
            idx_q   <= araddr_i[`PMEM_WORDS_LOG2+2:3];
            wdata_q <= '0;
            wstrb_q <= '0;                         // reads carry no strobes
            id_q    <= arid_i;
            err_q   <= bad_request(araddr_i, arlen_i, arsize_i);
        end
    end

    assign req.valid = (state_q == pmem_pkg::accept_hold);
    assign req.op    = op_q;
    assign req.idx   = idx_q;
    assign req.wdata = wdata_q;
    assign req.wstrb = wstrb_q;
    assign req.id    = id_q;
    assign req.err   = err_q;

endmodule

/* source/pmem_array.sv */
`timescale 1ns/1ps
`include "pmem_params.svh"

module pmem_array (
    input  logic          clock,
    input  logic          reset,
    mem_req_if.array_mp   req,
    mem_rsp_if.array_mp   rsp
);

    localparam int words = 1 << `PMEM_WORDS_LOG2;
    localparam int lanes = `PMEM_DATA_W / 8;

    axi_pkg::data_t      mem_q [0:words-1];

    logic                valid_q;
    pmem_pkg::mem_op_e   op_q;
    axi_pkg::id_t        id_q;
    axi_pkg::resp_e      resp_q;
    axi_pkg::data_t      rdata_q;

    logic                xfer;
    logic                do_write;
    logic                do_read;

    assign xfer     = req.valid && req.ready;
    assign do_write = xfer && !req.err && (req.op == pmem_pkg::op_write);
    assign do_read  = xfer && !req.err && (req.op == pmem_pkg::op_read);

    // a new access may enter when the output register is empty or drains now
    assign req.ready = !valid_q || rsp.ready;

    // byte lanes with their strobe set take the new data
    always_ff @(posedge clock) begin
        if (do_write) begin
            for (int b = 0; b < lanes; b++) begin
                if (req.wstrb[b]) begin
                    mem_q[req.idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (xfer) begin
            valid_q <= 1'b1;
        end else if (rsp.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (xfer) begin
            op_q   <= req.op;
            id_q   <= req.id;
            resp_q <= req.err ? axi_pkg::slverr : axi_pkg::okay;
            if (do_read) begin
                rdata_q <= mem_q[req.idx];     // old contents, whole aligned word
            end else begin
                rdata_q <= '0;                 // writes and rejected requests return zero
            end
        end
    end

    assign rsp.valid = valid_q;
    assign rsp.op    = op_q;
    assign rsp.id    = id_q;
    assign rsp.resp  = resp_q;
    assign rsp.rdata = rdata_q;

endmodule

/* source/pmem_params.svh */
`ifndef PMEM_PARAMS_SVH
`define PMEM_PARAMS_SVH

// byte address width on the AXI side
`define PMEM_ADDR_W 32

`define PMEM_DATA_W 64          // one array word per beat, eight byte lanes

`define PMEM_ID_W 4             // transaction ID, echoed on bid and rid

// 1024 words of 8 bytes gives 8 KiB of storage
`define PMEM_WORDS_LOG2 10

`endif

/* source/pmem_pkg.sv */
`include "pmem_params.svh"

package pmem_pkg;

    // kind of access that travels down the pipeline
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    typedef logic [`PMEM_WORDS_LOG2-1:0] word_idx_t;  // word index into the array

    // request register in the accept stage
    typedef enum logic {
        accept_idle = 1'b0,
        accept_hold = 1'b1
    } accept_state_e;

    // holding register in the respond stage
    typedef enum logic {
        respond_empty = 1'b0,
        respond_full  = 1'b1
    } respond_state_e;

endpackage

/* source/pmem_respond.sv */
`timescale 1ns/1ps

module pmem_respond (
    input  logic              clock,
    input  logic              reset,
    mem_rsp_if.respond_mp     rsp,

    input  logic              bready_i,
    output logic              bvalid_o,
    output axi_pkg::resp_e    bresp_o,
    output axi_pkg::id_t      bid_o,

    input  logic              rready_i,
    output logic              rvalid_o,
    output axi_pkg::resp_e    rresp_o,
    output axi_pkg::data_t    rdata_o,
    output logic              rlast_o,
    output axi_pkg::id_t      rid_o
);

    pmem_pkg::respond_state_e state_q;

    pmem_pkg::mem_op_e        op_q;
    axi_pkg::id_t             id_q;
    axi_pkg::resp_e           resp_q;
    axi_pkg::data_t           rdata_q;

    logic                     full;
    logic                     is_write;
    logic                     freed;
    logic                     xfer;

    assign full     = (state_q == pmem_pkg::respond_full);
    assign is_write = (op_q == pmem_pkg::op_write);

    // the held response leaves on the ready of the channel it is shown on
    assign freed = full && (is_write ? bready_i : rready_i);

    assign rsp.ready = !full || freed;
    assign xfer      = rsp.valid && rsp.ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= pmem_pkg::respond_empty;
        end else if (xfer) begin
            state_q <= pmem_pkg::respond_full;
        end else if (freed) begin
            state_q <= pmem_pkg::respond_empty;
        end
    end

    // payload only changes when a new response is taken, so it stays stable under stall
    always_ff @(posedge clock) begin
        if (xfer) begin
            op_q    <= rsp.op;
            id_q    <= rsp.id;
            resp_q  <= rsp.resp;
            rdata_q <= rsp.rdata;
        end
    end

    assign bvalid_o = full && is_write;
    assign bresp_o  = resp_q;
    assign bid_o    = id_q;

    assign rvalid_o = full && !is_write;
    assign rresp_o  = resp_q;
    assign rdata_o  = rdata_q;
    assign rlast_o  = rvalid_o;     // every read is a single beat
    assign rid_o    = id_q;

endmodule

/* source/pmem_top.sv */
`timescale 1ns/1ps

module pmem_top (
    input  logic              clock,
    input  logic              reset,

    output logic              awready_o,
    input  logic              awvalid_i,
    input  axi_pkg::addr_t    awaddr_i,
    input  axi_pkg::id_t      awid_i,
    input  axi_pkg::len_t     awlen_i,
    input  axi_pkg::size_t    awsize_i,
    input  axi_pkg::burst_t   awburst_i,    // only single beats are served, so the type is moot

    output logic              wready_o,
    input  logic              wvalid_i,
    input  axi_pkg::data_t    wdata_i,
    input  axi_pkg::strb_t    wstrb_i,
    input  logic              wlast_i,      // always the only beat

    input  logic              bready_i,
    output logic              bvalid_o,
    output axi_pkg::resp_e    bresp_o,
    output axi_pkg::id_t      bid_o,

    output logic              arready_o,
    input  logic              arvalid_i,
    input  axi_pkg::addr_t    araddr_i,
    input  axi_pkg::id_t      arid_i,
    input  axi_pkg::len_t     arlen_i,
    input  axi_pkg::size_t    arsize_i,
    input  axi_pkg::burst_t   arburst_i,

    input  logic              rready_i,
    output logic              rvalid_o,
    output axi_pkg::resp_e    rresp_o,
    output axi_pkg::data_t    rdata_o,
    output logic              rlast_o,
    output axi_pkg::id_t      rid_o
);

    mem_req_if req_bus ();
    mem_rsp_if rsp_bus ();

    pmem_accept accept0 (
        .clock     (clock),
        .reset     (reset),
        .awvalid_i (awvalid_i),
        .awaddr_i  (awaddr_i),
        .awid_i    (awid_i),
        .awlen_i   (awlen_i),
        .awsize_i  (awsize_i),
        .awready_o (awready_o),
        .wvalid_i  (wvalid_i),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wready_o  (wready_o),
        .arvalid_i (arvalid_i),
        .araddr_i  (araddr_i),
        .arid_i    (arid_i),
        .arlen_i   (arlen_i),
        .arsize_i  (arsize_i),
        .arready_o (arready_o),
        .req       (req_bus.accept_mp)
    );

    pmem_array array0 (
        .clock (clock),
        .reset (reset),
        .req   (req_bus.array_mp),
        .rsp   (rsp_bus.array_mp)
    );

    pmem_respond respond0 (
        .clock    (clock),
        .reset    (reset),
        .rsp      (rsp_bus.respond_mp),
        .bready_i (bready_i),
        .bvalid_o (bvalid_o),
        .bresp_o  (bresp_o),
        .bid_o    (bid_o),
        .rready_i (rready_i),
        .rvalid_o (rvalid_o),
        .rresp_o  (rresp_o),
        .rdata_o  (rdata_o),
        .rlast_o  (rlast_o),
        .rid_o    (rid_o)
    );

endmodule
